// File: all.f
+incdir+rtl
+incdir+bench
rtl/decode_pkg.sv
rtl/inst_controller.sv
rtl/regfile.sv
rtl/reg_scoreboard.sv
rtl/hazard.sv
rtl/decode.sv
bench/decode_tb.sv

// File: bench/decode_vectors.svh
// Columns: name, inst, pc_inc, wb {en, adr}, stim {ex_ready, flush, stall, blocked},
// flags {regwrite, mem_read, mem_write, is_halt}, dest, alu_op, imm.

typedef struct {
   string                name;
   logic [`XLEN-1:0]     inst;
   logic [`XLEN-1:0]     pc_inc;
   logic                 wb_en;
   logic [`REG_BITS-1:0] wb_adr;
   logic [`XLEN-1:0]     wb_dat;
   logic                 ex_ready;
   logic                 flush;
   logic                 stall;
   logic                 blocked;
   logic [3:0]           flags;
   logic [`REG_BITS-1:0] dest;
   logic [3:0]           alu_op;
   logic [`XLEN-1:0]     imm;
} vec_t;

localparam int NVEC = 23;

vec_t vectors [NVEC];
int   nrows;

task automatic add_row(input string name, input logic [15:0] inst, input logic [15:0] pc_inc,
                       input logic [3:0] wb, input logic [3:0] stim, input logic [3:0] flags,
                       input logic [2:0] dest, input logic [3:0] alu_op,
                       input logic [15:0] imm);
   vec_t v;
   v.name     = name;
   v.inst     = inst;
   v.pc_inc   = pc_inc;
   v.wb_en    = wb[3];
   v.wb_adr   = wb[2:0];
   v.wb_dat   = wb[3] ? 16'($random(seed)) : 16'h0000;   // Operand words.
   v.ex_ready = stim[3];
   v.flush    = stim[2];
   v.stall    = stim[1];
   v.blocked  = stim[0];
   v.flags    = flags;
   v.dest     = dest;
   v.alu_op   = alu_op;
   v.imm      = imm;
   vectors[nrows] = v;
   nrows++;
endtask

task automatic load_vectors();
   nrows = 0;
   add_row("li_r1",     16'h8185, 16'h0002, 4'b0000, 4'b1000, 4'b1000, 3'd1, 4'd6,  16'hff85);
   add_row("li_r2",     16'h8212, 16'h0004, 4'b1001, 4'b1000, 4'b1000, 3'd2, 4'd6,  16'h0012);
   add_row("add_rd_r1", 16'hcb00, 16'h0006, 4'b1010, 4'b1000, 4'b1000, 3'd3, 4'd0,  16'h0000);
   // SUB waits on r3 until the row's writeback lands.
   add_row("sub_stall", 16'hdc10, 16'h0008, 4'b1011, 4'b1010, 4'b1000, 3'd4, 4'd1,  16'h0010);
   add_row("store_bp",  16'h51f0, 16'h000a, 4'b1100, 4'b0000, 4'b0010, 3'd1, 4'd0,  16'hfff0);
   add_row("load_r5",   16'h2a7f, 16'h000c, 4'b0000, 4'b1000, 4'b1100, 3'd5, 4'd0,  16'h007f);
   add_row("mov_flush", 16'hee60, 16'h000e, 4'b0000, 4'b1110, 4'b1000, 3'd6, 4'd6,  16'h0060);
   add_row("cmp_bp",    16'he250, 16'h0010, 4'b0000, 4'b0000, 4'b0000, 3'd2, 4'd5,  16'h0050);
   add_row("br_b",      16'ha004, 16'h0012, 4'b0000, 4'b1000, 4'b0000, 3'd0, 4'd0,  16'h0004);
   add_row("br_be",     16'ha8fc, 16'h0014, 4'b0000, 4'b1000, 4'b0000, 3'd0, 4'd0,  16'hfffc);
   add_row("br_blt",    16'hb080, 16'h0016, 4'b0000, 4'b1000, 4'b0000, 3'd0, 4'd0,  16'hff80);
   add_row("br_ble",    16'hb801, 16'h0018, 4'b0000, 4'b1000, 4'b0000, 3'd0, 4'd0,  16'h0001);
   add_row("br_bne",    16'h987e, 16'h001a, 4'b0000, 4'b1000, 4'b0000, 3'd0, 4'd0,  16'h007e);
   add_row("br_nop",    16'h9003, 16'h001c, 4'b0000, 4'b1000, 4'b0000, 3'd0, 4'd14, 16'h0003);
   add_row("alu_nop",   16'hc0c0, 16'h001e, 4'b0000, 4'b1000, 4'b0000, 3'd0, 4'd14, 16'hffc0);
   add_row("out",       16'hd990, 16'h0020, 4'b0000, 4'b1000, 4'b0000, 3'd1, 4'd9,  16'hff90);
   add_row("or_r1",     16'hd130, 16'h0022, 4'b1110, 4'b1000, 4'b1000, 3'd1, 4'd3,  16'h0030);
   add_row("sll_r7",    16'hf770, 16'h0024, 4'b1001, 4'b1000, 4'b1000, 3'd7, 4'd7,  16'h0070);
   add_row("srl_stall", 16'hcf80, 16'h0026, 4'b1111, 4'b1010, 4'b1000, 3'd7, 4'd8,  16'hff80);
   add_row("xor_bp",    16'he840, 16'h0028, 4'b0000, 4'b0000, 4'b1000, 3'd0, 4'd4,  16'h0040);
   add_row("and_r2",    16'hda20, 16'h002a, 4'b0000, 4'b1000, 4'b1000, 3'd2, 4'd2,  16'h0020);
   add_row("hlt",       16'hc0f0, 16'h002c, 4'b0000, 4'b1000, 4'b0001, 3'd0, 4'd15, 16'hfff0);
   add_row("after_hlt", 16'h8301, 16'h002e, 4'b0000, 4'b1011, 4'b1000, 3'd3, 4'd6,  16'h0001);
endtask

// File: bench/decode_tb.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_tb import decode_pkg::*; ();

   localparam int HOLD    = 4;    // Cycles before the row's writeback, flush and ready.
   localparam int TIMEOUT = 50;

   logic             clk;
   logic             rst;
   logic             flush;
   if_id_t           in_inst;
   logic             in_ready;
   wb_t              wb_in;
   id_ex_t           ex_out;
   logic             ex_ready;
   logic             halted;
   logic [`XLEN-1:0] model [`NREGS];
   int               errors;
   int               seed;
   logic             timed_out;

   `include "decode_vectors.svh"

   decode u_decode (
      .clk      (clk),
      .rst      (rst),
      .flush    (flush),
      .in_inst  (in_inst),
      .in_ready (in_ready),
      .wb_in    (wb_in),
      .ex_out   (ex_out),
      .ex_ready (ex_ready),
      .halted   (halted)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ------------------------------------------------------------
   // Checks and reference register model
   // ------------------------------------------------------------
   task automatic check_val(input string test, input string field,
                            input logic [15:0] exp, input logic [15:0] act);
      assert (exp === act) else begin
         errors++;
         $display("FAILED %s %s: expected %h, actual %h", test, field, exp, act);
      end
   endtask

   task automatic check_true(input string test, input string what, input logic cond);
      assert (cond) else begin
         errors++;
         $display("ERROR %s: %s", test, what);
      end
   endtask

   task automatic apply_model_wb(input vec_t v);
      if (v.wb_en) begin
         model[v.wb_adr] = v.wb_dat;
      end
   endtask

   // Expected {is_branch, src_a_sel, src_b_sel}; selects are REG 0, IMM 1, PC_INC 2.
   function automatic logic [4:0] expected_routing(input logic [15:0] inst,
                                                   input logic [3:0] alu_op);
      case (inst[15:14])
         2'b00, 2'b01: return {1'b0, 2'd0, 2'd1};
         2'b10: begin
            if (alu_op == 4'd6) begin
               return {1'b0, 2'd1, 2'd1};        // LI.
            end else if (alu_op == 4'd0) begin
               return {1'b1, 2'd2, 2'd1};        // Branch.
            end else begin
               return {1'b0, 2'd0, 2'd0};
            end
         end
         default: return {1'b0, 2'd0, 2'd0};
      endcase
   endfunction

   // ------------------------------------------------------------
   // One table row
   // ------------------------------------------------------------
   task automatic run_row(input int i);
      vec_t             v;
      id_ex_t           held;
      id_ex_t           got_out;
      logic             held_ok;
      logic             accepted;
      logic             got;
      int               cyc;
      logic [3:0]       act_flags;
      logic [4:0]       act_routing;
      logic [`XLEN-1:0] exp_rd1;
      logic [`XLEN-1:0] exp_rd2;
      v        = vectors[i];
      held_ok  = 1'b0;
      accepted = 1'b0;
      got      = 1'b0;
      cyc      = 0;
      if (v.stall) begin
         apply_model_wb(v);                       // A stalled reader sees its wakeup value.
      end
      exp_rd1 = model[v.inst[`RA_HI:`RA_LO]];
      exp_rd2 = model[v.inst[`RB_HI:`RB_LO]];
      if (!v.stall) begin
         apply_model_wb(v);
      end
      in_inst.valid  = 1'b1;
      in_inst.inst   = v.inst;
      in_inst.pc_inc = v.pc_inc;
      ex_ready       = v.ex_ready;
      while (!(got && cyc > HOLD) && cyc < TIMEOUT) begin
         @(negedge clk);
         if ((v.stall && cyc < HOLD) || v.blocked) begin
            check_true(v.name, "in_ready high while the instruction should wait", !in_ready);
            check_true(v.name, "waiting instruction reached ex_out", !ex_out.valid);
         end
         if (v.flush && cyc == HOLD + 1) begin
            check_true(v.name, "ex_out valid after flush", !ex_out.valid);
            check_true(v.name, "in_ready high in the cycle after flush", !in_ready);
         end
         if (ex_out.valid && !ex_ready) begin
            if (!held_ok) begin
               held    = ex_out;
               held_ok = 1'b1;
            end else begin
               check_true(v.name, "ex_out changed while ex_ready was low", ex_out === held);
            end
         end
         if (in_inst.valid && in_ready) begin
            accepted = 1'b1;
         end
         if (ex_out.valid && ex_ready) begin
            check_true(v.name, "instruction left ex_out twice", !got);
            got     = 1'b1;
            got_out = ex_out;
         end
         @(posedge clk);
         #2;
         wb_in = '0;
         flush = 1'b0;
         if (accepted) begin
            in_inst.valid = 1'b0;
         end
         cyc++;
         if (cyc == HOLD) begin
            wb_in.en  = v.wb_en;
            wb_in.adr = v.wb_adr;
            wb_in.dat = v.wb_dat;
            flush     = v.flush;
            ex_ready  = 1'b1;
         end
      end
      if (v.blocked) begin
         check_true(v.name, "instruction passed a halt", !got);
         check_true(v.name, "halted is low after HLT", halted);
         if (!got) begin
            $display("%s: no output within %0d cycles after halt, as expected", v.name, TIMEOUT);
         end
      end else if (!got) begin
         errors++;
         timed_out = 1'b1;
         $display("ERROR %s: timeout waiting for ex_out.valid", v.name);
      end else begin
         act_flags   = {got_out.ctrl.regwrite, got_out.ctrl.mem_read,
                        got_out.ctrl.mem_write, got_out.ctrl.is_halt};
         act_routing = {got_out.ctrl.is_branch, got_out.ctrl.src_a_sel,
                        got_out.ctrl.src_b_sel};
         check_val(v.name, "pc_inc", v.pc_inc, got_out.pc_inc);   // Also proves the order.
         check_val(v.name, "imm", v.imm, got_out.imm);
         check_val(v.name, "rd1", exp_rd1, got_out.rd1);
         check_val(v.name, "rd2", exp_rd2, got_out.rd2);
         check_val(v.name, "alu_op", 16'(v.alu_op), 16'(got_out.ctrl.alu_op));
         check_val(v.name, "flags", 16'(v.flags), 16'(act_flags));
         check_val(v.name, "routing", 16'(expected_routing(v.inst, v.alu_op)),
                   16'(act_routing));
         if (v.flags[3]) begin
            check_val(v.name, "dest", 16'(v.dest), 16'(got_out.ctrl.dest));
         end
      end
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin
      seed      = 30;
      errors    = 0;
      timed_out = 1'b0;
      rst       = 1'b1;
      flush     = 1'b0;
      in_inst   = '0;
      wb_in     = '0;
      ex_ready  = 1'b0;
      for (int r = 0; r < `NREGS; r++) begin
         model[r] = '0;
      end
      load_vectors();
      repeat (5) @(posedge clk);
      #2;
      rst      = 1'b0;
      ex_ready = 1'b1;
      for (int i = 0; i < NVEC && !timed_out; i++) begin
         run_row(i);
      end
      $display("decode_tb finished with %0d errors", errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: rtl/decode.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode import decode_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   flush,
   input  if_id_t in_inst,
   output logic   in_ready,
   input  wb_t    wb_in,
   output id_ex_t ex_out,
   input  logic   ex_ready,
   output logic   halted
);

   ctrl_t              ctrl;
   logic [`XLEN-1:0]   imm;
   logic [`XLEN-1:0]   rd1;
   logic [`XLEN-1:0]   rd2;
   logic [`NREGS-1:0]  busy;
   logic               accept;
   logic               load_ex;
   id_ex_t             ex_next;

   // ------------------------------------------------------------
   // Decode, operand read and hazard blocks
   // ------------------------------------------------------------
   inst_controller u_inst_controller (
      .inst (in_inst.inst),
      .ctrl (ctrl),
      .imm  (imm)
   );

   regfile u_regfile (
      .clk (clk),
      .rst (rst),
      .ra  (ctrl.ra),
      .rb  (ctrl.rb),
      .wb  (wb_in),
      .rd1 (rd1),
      .rd2 (rd2)
   );

   reg_scoreboard u_reg_scoreboard (
      .clk       (clk),
      .rst       (rst),
      .flush     (flush),
      .issue_en  (accept && ctrl.regwrite),   // Counted when it enters the pipe.
      .issue_adr (ctrl.dest),
      .wb        (wb_in),
      .busy      (busy)
   );

   hazard u_hazard (
      .clk       (clk),
      .rst       (rst),
      .flush     (flush),
      .in_valid  (in_inst.valid),
      .ctrl      (ctrl),
      .busy      (busy),
      .out_valid (ex_out.valid),
      .ex_ready  (ex_ready),
      .in_ready  (in_ready),
      .accept    (accept),
      .load_ex   (load_ex),
      .halted    (halted)
   );

   // ------------------------------------------------------------
   // Decode to execute register
   // ------------------------------------------------------------
   always_comb begin
      ex_next.valid  = accept;                 // Bubble when nothing accepted.
      ex_next.ctrl   = ctrl;
      ex_next.rd1    = rd1;
      ex_next.rd2    = rd2;
      ex_next.imm    = imm;
      ex_next.pc_inc = in_inst.pc_inc;
   end

   always_ff @(posedge clk) begin
      if (load_ex) begin
         ex_out <= ex_next;
      end
      if (rst || flush) begin
         ex_out.valid <= 1'b0;
      end
   end

endmodule

// File: rtl/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// ------------------------------------------------------------
// Machine widths
// ------------------------------------------------------------
`define XLEN      16
`define NREGS     8
`define REG_BITS  3
`define SB_BITS   3
`define IMM_BITS  8

// ------------------------------------------------------------
// Instruction field positions
// ------------------------------------------------------------
`define CLS_HI    15
`define CLS_LO    14
`define RA_HI     13
`define RA_LO     11
`define RB_HI     10
`define RB_LO     8
`define OP_HI     7
`define OP_LO     4

`endif

// File: rtl/decode_pkg.sv
`include "decode_consts.svh"

package decode_pkg;

   // ------------------------------------------------------------
   // Encodings
   // ------------------------------------------------------------
   typedef enum logic [1:0] {
      CLS_LOAD   = 2'b00,
      CLS_STORE  = 2'b01,
      CLS_IMM_BR = 2'b10,
      CLS_ALU    = 2'b11
   } inst_class_t;

   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_CMP = 4'd5,
      ALU_MOV = 4'd6,
      ALU_SLL = 4'd7,
      ALU_SRL = 4'd8,
      ALU_OUT = 4'd9,
      ALU_NOP = 4'd14,   // Unused codes collapse here.
      ALU_HLT = 4'd15
   } alu_op_t;

   typedef enum logic [2:0] {
      BR_LI  = 3'd0,
      BR_NOP = 3'd1,
      BR_BNE = 3'd3,
      BR_B   = 3'd4,
      BR_BE  = 3'd5,
      BR_BLT = 3'd6,
      BR_BLE = 3'd7
   } br_op_t;

   typedef enum logic [1:0] {
      SRC_REG    = 2'd0,
      SRC_IMM    = 2'd1,
      SRC_PC_INC = 2'd2
   } src_sel_t;

   // ------------------------------------------------------------
   // Stage records
   // ------------------------------------------------------------
   typedef struct packed {
      logic                 valid;
      logic [`XLEN-1:0]     inst;
      logic [`XLEN-1:0]     pc_inc;
   } if_id_t;

   typedef struct packed {
      logic                 en;
      logic [`REG_BITS-1:0] adr;
      logic [`XLEN-1:0]     dat;
   } wb_t;

   typedef struct packed {
      alu_op_t              alu_op;
      br_op_t               br_op;
      logic                 is_branch;
      src_sel_t             src_a_sel;
      src_sel_t             src_b_sel;
      logic [`REG_BITS-1:0] dest;
      logic                 regwrite;
      logic                 mem_read;
      logic                 mem_write;
      logic                 is_halt;
      logic                 use_ra;
      logic                 use_rb;
      logic [`REG_BITS-1:0] ra;
      logic [`REG_BITS-1:0] rb;
   } ctrl_t;

   typedef struct packed {
      logic                 valid;
      ctrl_t                ctrl;
      logic [`XLEN-1:0]     rd1;
      logic [`XLEN-1:0]     rd2;
      logic [`XLEN-1:0]     imm;
      logic [`XLEN-1:0]     pc_inc;
   } id_ex_t;

endpackage

// File: rtl/hazard.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module hazard import decode_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              flush,
   input  logic              in_valid,
   input  ctrl_t             ctrl,
   input  logic [`NREGS-1:0] busy,
   input  logic              out_valid,
   input  logic              ex_ready,
   output logic              in_ready,
   output logic              accept,
   output logic              load_ex,
   output logic              halted
);

   logic data_hazard;
   logic recover;
   logic slot_free;

   assign data_hazard = (ctrl.use_ra && busy[ctrl.ra]) ||
                        (ctrl.use_rb && busy[ctrl.rb]);

   assign slot_free = !out_valid || ex_ready;   // Empty or draining.
   assign load_ex   = slot_free;

   assign in_ready = !data_hazard && !halted && !recover && !flush && slot_free;
   assign accept   = in_valid && in_ready;

   // ------------------------------------------------------------
   // Halt latch and flush recovery
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         halted  <= 1'b0;
         recover <= 1'b0;
      end else begin
         recover <= flush;                      // One dead cycle after flush.
         if (accept && ctrl.is_halt) begin
            halted <= 1'b1;
         end
      end
   end

   // A held entry must still be there on the next edge.
   a_hold_on_stall: assert property (
      @(posedge clk) disable iff (rst)
      (out_valid && !ex_ready && !flush) |=> out_valid
   ) else $error("hazard: held output entry was lost");

endmodule

// File: rtl/inst_controller.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module inst_controller import decode_pkg::*; (
   input  logic [`XLEN-1:0] inst,
   output ctrl_t            ctrl,
   output logic [`XLEN-1:0] imm
);

   inst_class_t cls;
   alu_op_t     op;
   br_op_t      bop;

   assign cls = inst_class_t'(inst[`CLS_HI:`CLS_LO]);
   assign op  = alu_op_t'(inst[`OP_HI:`OP_LO]);
   assign bop = br_op_t'(inst[`RA_HI:`RA_LO]);

   // Displacement and LI constant share the low byte.
   assign imm = {{(`XLEN-`IMM_BITS){inst[`IMM_BITS-1]}}, inst[`IMM_BITS-1:0]};

   always_comb begin
      ctrl.alu_op    = ALU_NOP;
      ctrl.br_op     = BR_NOP;
      ctrl.is_branch = 1'b0;
      ctrl.src_a_sel = SRC_REG;
      ctrl.src_b_sel = SRC_REG;
      ctrl.dest      = inst[`RB_HI:`RB_LO];
      ctrl.regwrite  = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.is_halt   = 1'b0;
      ctrl.use_ra    = 1'b0;
      ctrl.use_rb    = 1'b0;
      ctrl.ra        = inst[`RA_HI:`RA_LO];
      ctrl.rb        = inst[`RB_HI:`RB_LO];

      case (cls)
         CLS_LOAD: begin
            ctrl.alu_op    = ALU_ADD;              // Base plus displacement.
            ctrl.src_b_sel = SRC_IMM;
            ctrl.dest      = inst[`RA_HI:`RA_LO];
            ctrl.regwrite  = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.use_rb    = 1'b1;
         end
         CLS_STORE: begin
            ctrl.alu_op    = ALU_ADD;
            ctrl.src_b_sel = SRC_IMM;
            ctrl.mem_write = 1'b1;
            ctrl.use_ra    = 1'b1;                 // Store data.
            ctrl.use_rb    = 1'b1;
         end
         CLS_IMM_BR: begin
            case (bop)
               BR_LI: begin
                  ctrl.br_op     = BR_LI;
                  ctrl.alu_op    = ALU_MOV;
                  ctrl.src_a_sel = SRC_IMM;
                  ctrl.src_b_sel = SRC_IMM;
                  ctrl.regwrite  = 1'b1;
               end
               BR_B, BR_BE, BR_BLT, BR_BLE, BR_BNE: begin
                  ctrl.br_op     = bop;
                  ctrl.alu_op    = ALU_ADD;        // Target is pc_inc plus offset.
                  ctrl.is_branch = 1'b1;
                  ctrl.src_a_sel = SRC_PC_INC;
                  ctrl.src_b_sel = SRC_IMM;
               end
               default: ctrl.br_op = BR_NOP;
            endcase
         end
         CLS_ALU: begin
            case (op)
               ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL: begin
                  ctrl.alu_op   = op;
                  ctrl.regwrite = 1'b1;
                  ctrl.use_ra   = 1'b1;
                  ctrl.use_rb   = 1'b1;
               end
               ALU_CMP, ALU_OUT: begin
                  ctrl.alu_op = op;                // Reads both, writes nothing.
                  ctrl.use_ra = 1'b1;
                  ctrl.use_rb = 1'b1;
               end
               ALU_MOV: begin
                  ctrl.alu_op   = ALU_MOV;
                  ctrl.regwrite = 1'b1;
                  ctrl.use_ra   = 1'b1;
               end
               ALU_HLT: begin
                  ctrl.alu_op  = ALU_HLT;
                  ctrl.is_halt = 1'b1;
               end
               default: ctrl.alu_op = ALU_NOP;
            endcase
         end
         default: ctrl.alu_op = ALU_NOP;
      endcase
   end

endmodule

// File: rtl/reg_scoreboard.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module reg_scoreboard import decode_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 flush,
   input  logic                 issue_en,
   input  logic [`REG_BITS-1:0] issue_adr,
   input  wb_t                  wb,
   output logic [`NREGS-1:0]    busy
);

   logic [`NREGS-1:0][`SB_BITS-1:0] cnt;

   // ------------------------------------------------------------
   // One in-flight write counter per register
   // ------------------------------------------------------------
   for (genvar i = 0; i < `NREGS; i++) begin : g_cnt
      logic inc;
      logic dec;

      assign inc = issue_en && (issue_adr == `REG_BITS'(i));
      assign dec = wb.en && (wb.adr == `REG_BITS'(i));

      always_ff @(posedge clk) begin
         if (rst || flush) begin
            cnt[i] <= '0;                      // Flushed writes never return.
         end else if (inc && !dec) begin
            cnt[i] <= cnt[i] + 1'b1;
         end else if (dec && !inc) begin
            cnt[i] <= cnt[i] - 1'b1;
         end
      end

      assign busy[i] = (cnt[i] != '0);

      // Too many writes to one register in flight at once.
      a_no_overflow: assert property (
         @(posedge clk) disable iff (rst || flush)
         (inc && !dec) |-> (cnt[i] != '1)
      ) else $error("scoreboard: counter %0d overflow", i);

      // Writeback arrived for a register with nothing pending.
      a_no_underflow: assert property (
         @(posedge clk) disable iff (rst || flush)
         (dec && !inc) |-> (cnt[i] != '0)
      ) else $error("scoreboard: counter %0d underflow", i);
   end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "decode_consts.svh"

module regfile import decode_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [`REG_BITS-1:0] ra,
   input  logic [`REG_BITS-1:0] rb,
   input  wb_t                  wb,
   output logic [`XLEN-1:0]     rd1,
   output logic [`XLEN-1:0]     rd2
);

   logic [`XLEN-1:0] regs [`NREGS];

   // ------------------------------------------------------------
   // Write port
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.en) begin
         regs[wb.adr] <= wb.dat;
      end
   end

   // No bypass; a reader waits one edge past the writeback.
   assign rd1 = regs[ra];
   assign rd2 = regs[rb];

   a_wb_adr_known: assert property (
      @(posedge clk) disable iff (rst)
      wb.en |-> !$isunknown(wb.adr)
   ) else $error("regfile: writeback address unknown");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module decode_tb \
   --Mdir obj_dir -o decode_tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/decode_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
   exit 1
fi
exit 0
